// ==== verilog/mem_sched_pkg.sv ====
package mem_sched_pkg;

    //////////////////////////////////////////////////
    // Sizes
    //////////////////////////////////////////////////

    localparam int NUM_PORTS   = 3;
    localparam int ADDR_W      = 32;
    localparam int DATA_W      = 64;
    localparam int PID_W       = 7;
    localparam int SLOT_W      = 7;
    localparam int DMA_ID_W    = 4;
    localparam int PORT_IDX_W  = 2;
    localparam int REQ_DEPTH   = 4;
    localparam int TAG_DEPTH   = 8;
    localparam int RET_DEPTH   = 4;
    // Waiting cycles before DMA overrides the ports
    localparam int DMA_TIMEOUT = 15;

    //////////////////////////////////////////////////
    // Payloads
    //////////////////////////////////////////////////

    typedef struct packed {
        logic                  wr;
        logic [ADDR_W-1:0]     addr;
        logic [DATA_W-1:0]     data;
        logic [PID_W-1:0]      pid;
        logic [SLOT_W-1:0]     slot;
    } port_req_t;

    typedef struct packed {
        logic                  wr;
        logic [ADDR_W-1:0]     addr;
        logic [DATA_W-1:0]     data;
    } mem_cmd_t;

    typedef struct packed {
        mem_cmd_t              cmd;
        logic [DMA_ID_W-1:0]   dma_id;
    } dma_req_t;

    typedef struct packed {
        logic [DATA_W-1:0]     data;
        logic [DMA_ID_W-1:0]   dma_id;
    } dma_resp_t;

    // Owner of one outstanding read
    typedef struct packed {
        logic                  is_dma;
        logic [DMA_ID_W-1:0]   dma_id;
        logic [PORT_IDX_W-1:0] port;
        logic [PID_W-1:0]      pid;
        logic [SLOT_W-1:0]     slot;
        logic [ADDR_W-1:0]     addr;
    } read_tag_t;

    typedef struct packed {
        logic [PID_W-1:0]      pid;
        logic [SLOT_W-1:0]     slot;
        logic [ADDR_W-1:0]     addr;
        logic [DATA_W-1:0]     data;
    } port_ret_t;

endpackage

// ==== verilog/sync_fifo.sv ====
`timescale 1ns/1ns

module sync_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 4
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     i_push,
    input  payload_t i_data,
    input  logic     i_pop,
    output payload_t o_data,
    output logic     o_empty,
    output logic     o_full
);

    payload_t                   mem [DEPTH];
    logic [$clog2(DEPTH)-1:0]   wr_ptr;
    logic [$clog2(DEPTH)-1:0]   rd_ptr;
    logic [$clog2(DEPTH):0]     count;
    logic                       do_push;
    logic                       do_pop;

    assign o_empty = (count == '0);
    assign o_full  = (int'(count) == DEPTH);
    // Head entry always visible
    assign o_data  = mem[rd_ptr];

    // Overflow and underflow are ignored
    assign do_push = i_push && !o_full;
    assign do_pop  = i_pop && !o_empty;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= i_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (int'(wr_ptr) == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (int'(rd_ptr) == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (!rst) !(i_push && o_full))
        else $error("sync_fifo: push while full, entry dropped");
    a_no_underflow: assert property (@(posedge clk) disable iff (!rst) !(i_pop && o_empty))
        else $error("sync_fifo: pop while empty");

endmodule

// ==== verilog/port_arbiter.sv ====
`timescale 1ns/1ns

module port_arbiter (
    input  logic                                        clk,
    input  logic                                        rst,
    input  logic [mem_sched_pkg::NUM_PORTS-1:0]         i_req_valid,
    input  mem_sched_pkg::port_req_t                    i_req [mem_sched_pkg::NUM_PORTS],
    input  logic                                        i_take,
    output logic [mem_sched_pkg::NUM_PORTS-1:0]         o_req_ready,
    output logic                                        o_offer_valid,
    output mem_sched_pkg::port_req_t                    o_offer,
    output logic [mem_sched_pkg::PORT_IDX_W-1:0]        o_offer_port
);

    import mem_sched_pkg::*;

    port_req_t              head [NUM_PORTS];
    logic [NUM_PORTS-1:0]   q_empty;
    logic [NUM_PORTS-1:0]   q_full;
    logic [NUM_PORTS-1:0]   q_pop;

    //////////////////////////////////////////////////
    // Request queues, one per decoder port
    //////////////////////////////////////////////////

    genvar g;
    generate
        for (g = 0; g < NUM_PORTS; g++) begin : g_req_q
            sync_fifo #(
                .payload_t (port_req_t),
                .DEPTH     (REQ_DEPTH)
            ) u_req_fifo (
                .clk     (clk),
                .rst     (rst),
                .i_push  (i_req_valid[g]),
                .i_data  (i_req[g]),
                .i_pop   (q_pop[g]),
                .o_data  (head[g]),
                .o_empty (q_empty[g]),
                .o_full  (q_full[g])
            );

            assign o_req_ready[g] = !q_full[g];
            // Only the offered queue is popped
            assign q_pop[g] = i_take && (o_offer_port == PORT_IDX_W'(g));
        end
    endgenerate

    //////////////////////////////////////////////////
    // Fixed priority, lowest index first
    //////////////////////////////////////////////////

    always_comb begin
        o_offer_valid = 1'b0;
        o_offer_port  = '0;
        o_offer       = head[0];
        // Walk downwards so the lowest non-empty index wins
        for (int p = NUM_PORTS - 1; p >= 0; p--) begin
            if (!q_empty[p]) begin
                o_offer_valid = 1'b1;
                o_offer_port  = PORT_IDX_W'(p);
                o_offer       = head[p];
            end
        end
    end

    // Memory issue must not take from an empty offer
    a_take_needs_offer: assert property (@(posedge clk) disable iff (!rst)
        i_take |-> o_offer_valid)
        else $error("port_arbiter: take without a valid offer");

endmodule

// ==== verilog/mem_issue.sv ====
`timescale 1ns/1ns

module mem_issue (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    i_offer_valid,
    input  mem_sched_pkg::port_req_t                i_offer,
    input  logic [mem_sched_pkg::PORT_IDX_W-1:0]    i_offer_port,
    input  logic                                    i_dma_valid,
    input  mem_sched_pkg::dma_req_t                 i_dma_req,
    input  logic                                    i_mem_ready,
    input  logic                                    i_tag_full,
    output logic                                    o_take,
    output logic                                    o_dma_taken,
    output logic                                    o_mem_valid,
    output mem_sched_pkg::mem_cmd_t                 o_mem_cmd,
    output logic                                    o_tag_push,
    output mem_sched_pkg::read_tag_t                o_tag
);

    import mem_sched_pkg::*;

    logic [$clog2(DMA_TIMEOUT+1)-1:0]   dma_wait;
    logic                               dma_expired;
    logic                               dma_first;
    logic                               port_ok;
    logic                               pick_port;
    logic                               pick_dma;

    //////////////////////////////////////////////////
    // DMA starvation timer
    //////////////////////////////////////////////////

    assign dma_expired = (int'(dma_wait) == DMA_TIMEOUT);

    always_ff @(posedge clk) begin
        if (!rst) begin
            dma_wait <= '0;
        end else if (!i_dma_valid || o_dma_taken) begin
            dma_wait <= '0;
        end else if (!dma_expired) begin
            // Saturates once expired
            dma_wait <= dma_wait + 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // Bus arbitration
    //////////////////////////////////////////////////

    always_comb begin
        // Expired DMA beats everything
        dma_first = i_dma_valid && dma_expired;
        // Port reads need a free tag slot, writes do not
        port_ok   = i_offer_valid && (i_offer.wr || !i_tag_full);
        pick_port = port_ok && !dma_first;
        pick_dma  = i_dma_valid && !pick_port;
    end

    assign o_mem_valid = i_mem_ready && (pick_port || pick_dma);
    assign o_take      = i_mem_ready && pick_port;
    assign o_dma_taken = i_mem_ready && pick_dma;

    // Command and read tag for the selected source
    always_comb begin
        o_tag = '0;
        if (pick_dma) begin
            o_mem_cmd    = i_dma_req.cmd;
            o_tag.is_dma = 1'b1;
            o_tag.dma_id = i_dma_req.dma_id;
            o_tag.addr   = i_dma_req.cmd.addr;
        end else begin
            o_mem_cmd.wr   = i_offer.wr;
            o_mem_cmd.addr = i_offer.addr;
            o_mem_cmd.data = i_offer.data;
            o_tag.is_dma   = 1'b0;
            o_tag.port     = i_offer_port;
            o_tag.pid      = i_offer.pid;
            o_tag.slot     = i_offer.slot;
            o_tag.addr     = i_offer.addr;
        end
    end

    // Every accepted read owns one tag
    assign o_tag_push = o_mem_valid && !o_mem_cmd.wr;

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    a_one_winner: assert property (@(posedge clk) disable iff (!rst)
        !(o_take && o_dma_taken))
        else $error("mem_issue: port and DMA taken in the same cycle");

endmodule

// ==== verilog/resp_router.sv ====
`timescale 1ns/1ns

module resp_router (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    i_tag_push,
    input  mem_sched_pkg::read_tag_t                i_tag,
    input  logic                                    i_mem_rvalid,
    input  logic [mem_sched_pkg::DATA_W-1:0]        i_mem_rdata,
    input  logic                                    i_dma_rready,
    input  logic [mem_sched_pkg::NUM_PORTS-1:0]     i_ret_pop,
    output logic                                    o_tag_full,
    output logic                                    o_mem_rtaken,
    output logic                                    o_dma_rvalid,
    output mem_sched_pkg::dma_resp_t                o_dma_resp,
    output logic [mem_sched_pkg::NUM_PORTS-1:0]     o_ret_valid,
    output mem_sched_pkg::port_ret_t                o_ret [mem_sched_pkg::NUM_PORTS]
);

    import mem_sched_pkg::*;

    read_tag_t              head_tag;
    logic                   tag_empty;
    logic                   port_room;
    port_ret_t              ret_entry;
    logic [NUM_PORTS-1:0]   ret_push;
    logic [NUM_PORTS-1:0]   ret_empty;
    logic [NUM_PORTS-1:0]   ret_full;

    // Outstanding reads in issue order
    sync_fifo #(
        .payload_t (read_tag_t),
        .DEPTH     (TAG_DEPTH)
    ) u_tag_fifo (
        .clk     (clk),
        .rst     (rst),
        .i_push  (i_tag_push),
        .i_data  (i_tag),
        .i_pop   (o_mem_rtaken),
        .o_data  (head_tag),
        .o_empty (tag_empty),
        .o_full  (o_tag_full)
    );

    //////////////////////////////////////////////////
    // Match returned word to head tag
    //////////////////////////////////////////////////

    always_comb begin
        port_room = 1'b0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (head_tag.port == PORT_IDX_W'(p)) begin
                port_room = !ret_full[p];
            end
        end
    end

    assign o_mem_rtaken = i_mem_rvalid && !tag_empty &&
                          (head_tag.is_dma ? i_dma_rready : port_room);

    // DMA path, same cycle
    assign o_dma_rvalid      = o_mem_rtaken && head_tag.is_dma;
    assign o_dma_resp.data   = i_mem_rdata;
    assign o_dma_resp.dma_id = head_tag.dma_id;

    assign ret_entry.pid  = head_tag.pid;
    assign ret_entry.slot = head_tag.slot;
    assign ret_entry.addr = head_tag.addr;
    assign ret_entry.data = i_mem_rdata;

    //////////////////////////////////////////////////
    // Port return queues
    //////////////////////////////////////////////////

    genvar g;
    generate
        for (g = 0; g < NUM_PORTS; g++) begin : g_ret_q
            assign ret_push[g] = o_mem_rtaken && !head_tag.is_dma &&
                                 (head_tag.port == PORT_IDX_W'(g));

            sync_fifo #(
                .payload_t (port_ret_t),
                .DEPTH     (RET_DEPTH)
            ) u_ret_fifo (
                .clk     (clk),
                .rst     (rst),
                .i_push  (ret_push[g]),
                .i_data  (ret_entry),
                .i_pop   (i_ret_pop[g]),
                .o_data  (o_ret[g]),
                .o_empty (ret_empty[g]),
                .o_full  (ret_full[g])
            );

            assign o_ret_valid[g] = !ret_empty[g];
        end
    endgenerate

    a_taken_needs_data: assert property (@(posedge clk) disable iff (!rst)
        o_mem_rtaken |-> i_mem_rvalid)
        else $error("resp_router: return taken without memory data");

    // Memory only returns reads that were issued
    a_data_has_owner: assert property (@(posedge clk) disable iff (!rst)
        i_mem_rvalid |-> !tag_empty)
        else $error("resp_router: read data with no outstanding tag");

endmodule

// ==== verilog/mem_sched_top.sv ====
`timescale 1ns/1ns

module mem_sched_top (
    input  logic                                    clk,
    input  logic                                    rst,
    // Decoder requests
    input  logic [mem_sched_pkg::NUM_PORTS-1:0]     i_req_valid,
    input  mem_sched_pkg::port_req_t                i_req [mem_sched_pkg::NUM_PORTS],
    output logic [mem_sched_pkg::NUM_PORTS-1:0]     o_req_ready,
    // DMA channel
    input  logic                                    i_dma_valid,
    input  mem_sched_pkg::dma_req_t                 i_dma_req,
    output logic                                    o_dma_taken,
    input  logic                                    i_dma_rready,
    output logic                                    o_dma_rvalid,
    output mem_sched_pkg::dma_resp_t                o_dma_resp,
    // Memory bus
    input  logic                                    i_mem_ready,
    output logic                                    o_mem_valid,
    output mem_sched_pkg::mem_cmd_t                 o_mem_cmd,
    input  logic                                    i_mem_rvalid,
    input  logic [mem_sched_pkg::DATA_W-1:0]        i_mem_rdata,
    output logic                                    o_mem_rtaken,
    // Port returns
    output logic [mem_sched_pkg::NUM_PORTS-1:0]     o_ret_valid,
    output mem_sched_pkg::port_ret_t                o_ret [mem_sched_pkg::NUM_PORTS],
    input  logic [mem_sched_pkg::NUM_PORTS-1:0]     i_ret_pop
);

    import mem_sched_pkg::*;

    logic                   offer_valid;
    port_req_t              offer;
    logic [PORT_IDX_W-1:0]  offer_port;
    logic                   take;
    logic                   tag_full;
    logic                   tag_push;
    read_tag_t              tag;

    port_arbiter u_port_arbiter (
        .clk           (clk),
        .rst           (rst),
        .i_req_valid   (i_req_valid),
        .i_req         (i_req),
        .i_take        (take),
        .o_req_ready   (o_req_ready),
        .o_offer_valid (offer_valid),
        .o_offer       (offer),
        .o_offer_port  (offer_port)
    );

    mem_issue u_mem_issue (
        .clk           (clk),
        .rst           (rst),
        .i_offer_valid (offer_valid),
        .i_offer       (offer),
        .i_offer_port  (offer_port),
        .i_dma_valid   (i_dma_valid),
        .i_dma_req     (i_dma_req),
        .i_mem_ready   (i_mem_ready),
        .i_tag_full    (tag_full),
        .o_take        (take),
        .o_dma_taken   (o_dma_taken),
        .o_mem_valid   (o_mem_valid),
        .o_mem_cmd     (o_mem_cmd),
        .o_tag_push    (tag_push),
        .o_tag         (tag)
    );

    resp_router u_resp_router (
        .clk           (clk),
        .rst           (rst),
        .i_tag_push    (tag_push),
        .i_tag         (tag),
        .i_mem_rvalid  (i_mem_rvalid),
        .i_mem_rdata   (i_mem_rdata),
        .i_dma_rready  (i_dma_rready),
        .i_ret_pop     (i_ret_pop),
        .o_tag_full    (tag_full),
        .o_mem_rtaken  (o_mem_rtaken),
        .o_dma_rvalid  (o_dma_rvalid),
        .o_dma_resp    (o_dma_resp),
        .o_ret_valid   (o_ret_valid),
        .o_ret         (o_ret)
    );

endmodule

// ==== verification/mem_sched_tb.sv ====
`timescale 1ns/1ns

module mem_sched_tb;

    import mem_sched_pkg::*;

    // Six short tests need a few hundred cycles, so this leaves wide margin
    localparam int                MAX_CYCLES = 3000;
    localparam int                WAIT_LIMIT = 100;
    localparam logic [DATA_W-1:0] RD_KEY     = 64'h5A5A_C3C3_0F0F_9669;

    logic                   clk = 1'b0;
    logic                   rst;
    logic [NUM_PORTS-1:0]   i_req_valid;
    port_req_t              i_req [NUM_PORTS];
    logic [NUM_PORTS-1:0]   o_req_ready;
    logic                   i_dma_valid;
    dma_req_t               i_dma_req;
    logic                   o_dma_taken;
    logic                   i_dma_rready;
    logic                   o_dma_rvalid;
    dma_resp_t              o_dma_resp;
    logic                   i_mem_ready;
    logic                   o_mem_valid;
    mem_cmd_t               o_mem_cmd;
    logic                   i_mem_rvalid = 1'b0;
    logic [DATA_W-1:0]      i_mem_rdata = '0;
    logic                   o_mem_rtaken;
    logic [NUM_PORTS-1:0]   o_ret_valid;
    port_ret_t              o_ret [NUM_PORTS];
    logic [NUM_PORTS-1:0]   i_ret_pop;

    int                     cycles = 0;
    int                     checks = 0;
    int                     errors = 0;
    mem_cmd_t               cmd_log [$];
    dma_resp_t              dma_log [$];
    logic [ADDR_W-1:0]      rd_addr_q [$];
    int                     rd_due_q [$];

    always #5 clk = ~clk;

    mem_sched_top dut (
        .clk          (clk),
        .rst          (rst),
        .i_req_valid  (i_req_valid),
        .i_req        (i_req),
        .o_req_ready  (o_req_ready),
        .i_dma_valid  (i_dma_valid),
        .i_dma_req    (i_dma_req),
        .o_dma_taken  (o_dma_taken),
        .i_dma_rready (i_dma_rready),
        .o_dma_rvalid (o_dma_rvalid),
        .o_dma_resp   (o_dma_resp),
        .i_mem_ready  (i_mem_ready),
        .o_mem_valid  (o_mem_valid),
        .o_mem_cmd    (o_mem_cmd),
        .i_mem_rvalid (i_mem_rvalid),
        .i_mem_rdata  (i_mem_rdata),
        .o_mem_rtaken (o_mem_rtaken),
        .o_ret_valid  (o_ret_valid),
        .o_ret        (o_ret),
        .i_ret_pop    (i_ret_pop)
    );

    //////////////////////////////////////////////////
    // Memory model and bus monitor
    //////////////////////////////////////////////////

    function automatic logic [DATA_W-1:0] mem_word(input logic [ADDR_W-1:0] addr);
        return DATA_W'(addr) ^ RD_KEY;
    endfunction

    // Handshakes complete at the next rising edge
    always @(negedge clk) begin
        if (rst) begin
            if (o_mem_valid && i_mem_ready) begin
                cmd_log.push_back(o_mem_cmd);
                if (!o_mem_cmd.wr) begin
                    rd_addr_q.push_back(o_mem_cmd.addr);
                    rd_due_q.push_back(cycles + 4);
                end
            end
            if (i_mem_rvalid && o_mem_rtaken) begin
                void'(rd_addr_q.pop_front());
                void'(rd_due_q.pop_front());
            end
            if (o_dma_rvalid) begin
                dma_log.push_back(o_dma_resp);
            end
        end
    end

    // Read data three cycles after acceptance, held until taken
    always @(posedge clk) begin
        #1;
        if (rd_addr_q.size() > 0 && rd_due_q[0] <= cycles) begin
            i_mem_rvalid = 1'b1;
            i_mem_rdata  = mem_word(rd_addr_q[0]);
        end else begin
            i_mem_rvalid = 1'b0;
            i_mem_rdata  = '0;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run exceeded %0d cycles", MAX_CYCLES);
            $display("Checks: %0d, errors: %0d", checks, errors);
            $display("Testbench failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////

    function automatic port_req_t random_req(input logic wr);
        port_req_t r;
        r.wr   = wr;
        r.addr = $urandom();
        r.data = {$urandom(), $urandom()};
        r.pid  = PID_W'($urandom());
        r.slot = SLOT_W'($urandom());
        return r;
    endfunction

    function automatic dma_req_t random_dma(input logic wr);
        dma_req_t d;
        d.cmd.wr   = wr;
        d.cmd.addr = $urandom();
        d.cmd.data = {$urandom(), $urandom()};
        d.dma_id   = DMA_ID_W'($urandom());
        return d;
    endfunction

    function automatic mem_cmd_t cmd_of(input port_req_t r);
        mem_cmd_t c;
        c.wr   = r.wr;
        c.addr = r.addr;
        c.data = r.data;
        return c;
    endfunction

    task automatic check(input string name, input logic [127:0] exp, input logic [127:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("[ERROR] %s expected 0x%0h got 0x%0h at cycle %0d", name, exp, act, cycles);
        end
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("Failure at cycle %0d: %s", cycles, what);
    endtask

    task automatic strobe_port(input int p, input port_req_t r);
        @(posedge clk);
        #1;
        i_req[p]       = r;
        i_req_valid[p] = 1'b1;
        @(posedge clk);
        #1;
        i_req_valid[p] = 1'b0;
    endtask

    task automatic expect_cmd(input string name, input mem_cmd_t exp);
        int n;
        n = 0;
        while (cmd_log.size() == 0 && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (cmd_log.size() == 0) begin
            report_failure({"no memory command seen for ", name});
        end else begin
            check(name, 128'(exp), 128'(cmd_log.pop_front()));
        end
    endtask

    task automatic expect_ret(input int p, input port_ret_t exp);
        int n;
        n = 0;
        @(negedge clk);
        while (!o_ret_valid[p] && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!o_ret_valid[p]) begin
            report_failure($sformatf("no return on port %0d", p));
        end else begin
            check($sformatf("o_ret[%0d].pid", p), 128'(exp.pid), 128'(o_ret[p].pid));
            check($sformatf("o_ret[%0d].slot", p), 128'(exp.slot), 128'(o_ret[p].slot));
            check($sformatf("o_ret[%0d].addr", p), 128'(exp.addr), 128'(o_ret[p].addr));
            check($sformatf("o_ret[%0d].data", p), 128'(exp.data), 128'(o_ret[p].data));
            @(posedge clk);
            #1;
            i_ret_pop[p] = 1'b1;
            @(posedge clk);
            #1;
            i_ret_pop[p] = 1'b0;
        end
    endtask

    // Holds the DMA request until taken, counts cycles from the rise of valid
    task automatic issue_dma(input dma_req_t r, output int waited);
        @(posedge clk);
        #1;
        i_dma_req   = r;
        i_dma_valid = 1'b1;
        waited      = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!o_dma_taken && waited < WAIT_LIMIT);
        if (!o_dma_taken) begin
            report_failure("DMA request was never taken");
        end
        @(posedge clk);
        #1;
        i_dma_valid = 1'b0;
    endtask

    task automatic expect_dma_resp(input dma_resp_t exp);
        int n;
        n = 0;
        while (dma_log.size() == 0 && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (dma_log.size() == 0) begin
            report_failure("no DMA response seen");
        end else begin
            check("o_dma_resp", 128'(exp), 128'(dma_log.pop_front()));
        end
    endtask

    //////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////

    task automatic test_reset_state();
        @(negedge clk);
        check("o_mem_valid", '0, 128'(o_mem_valid));
        check("o_dma_taken", '0, 128'(o_dma_taken));
        check("o_mem_rtaken", '0, 128'(o_mem_rtaken));
        check("o_dma_rvalid", '0, 128'(o_dma_rvalid));
        check("o_ret_valid", '0, 128'(o_ret_valid));
        check("o_req_ready", 128'({NUM_PORTS{1'b1}}), 128'(o_req_ready));
    endtask

    task automatic test_port_read();
        port_req_t r;
        port_ret_t exp;
        for (int p = 0; p < NUM_PORTS; p++) begin
            r        = random_req(1'b0);
            exp.pid  = r.pid;
            exp.slot = r.slot;
            exp.addr = r.addr;
            exp.data = mem_word(r.addr);
            strobe_port(p, r);
            expect_cmd("o_mem_cmd", cmd_of(r));
            expect_ret(p, exp);
        end
    endtask

    task automatic test_port_write();
        port_req_t r;
        r = random_req(1'b1);
        strobe_port(1, r);
        expect_cmd("o_mem_cmd", cmd_of(r));
        repeat (8) @(negedge clk);
        check("o_ret_valid", '0, 128'(o_ret_valid));
        check("DMA response count", '0, 128'(dma_log.size()));
    endtask

    task automatic test_port_order();
        port_req_t r [NUM_PORTS];
        @(posedge clk);
        #1;
        for (int p = 0; p < NUM_PORTS; p++) begin
            r[p]     = random_req(1'b1);
            i_req[p] = r[p];
        end
        i_req_valid = '1;
        @(posedge clk);
        #1;
        i_req_valid = '0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            expect_cmd($sformatf("o_mem_cmd from port %0d", p), cmd_of(r[p]));
        end
    endtask

    task automatic test_dma();
        dma_req_t  d;
        dma_resp_t exp;
        int        waited;
        d = random_dma(1'b0);
        issue_dma(d, waited);
        expect_cmd("o_mem_cmd DMA read", d.cmd);
        exp.data   = mem_word(d.cmd.addr);
        exp.dma_id = d.dma_id;
        expect_dma_resp(exp);
        d = random_dma(1'b1);
        issue_dma(d, waited);
        expect_cmd("o_mem_cmd DMA write", d.cmd);
    endtask

    task automatic test_dma_starvation();
        dma_req_t d;
        int       waited;
        int       hits;
        d    = random_dma(1'b1);
        hits = 0;
        fork
            begin
                // Port 0 writes every cycle keep the offer valid
                repeat (DMA_TIMEOUT + 12) begin
                    @(posedge clk);
                    #1;
                    i_req[0]       = random_req(1'b1);
                    i_req_valid[0] = o_req_ready[0];
                end
                @(posedge clk);
                #1;
                i_req_valid[0] = 1'b0;
            end
            begin
                repeat (3) @(posedge clk);
                issue_dma(d, waited);
            end
        join
        if (waited > DMA_TIMEOUT + 2) begin
            report_failure($sformatf("DMA waited %0d cycles under port load", waited));
        end
        repeat (8) @(negedge clk);
        while (cmd_log.size() > 0) begin
            if (cmd_log.pop_front() == d.cmd) begin
                hits++;
            end
        end
        check("DMA write commands on bus", 128'(1), 128'(hits));
    endtask

    initial begin
        void'($urandom(18));
        rst          = 1'b0;
        i_req_valid  = '0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            i_req[p] = '0;
        end
        i_dma_valid  = 1'b0;
        i_dma_req    = '0;
        i_dma_rready = 1'b1;
        i_mem_ready  = 1'b1;
        i_ret_pop    = '0;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b1;

        test_reset_state();
        test_port_read();
        test_port_write();
        test_port_order();
        test_dma();
        test_dma_starvation();

        repeat (5) @(posedge clk);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== project.f ====
verilog/mem_sched_pkg.sv
verilog/sync_fifo.sv
verilog/port_arbiter.sv
verilog/mem_issue.sv
verilog/resp_router.sv
verilog/mem_sched_top.sv
verification/mem_sched_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the scheduler testbench with Verilator
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f project.f --top-module mem_sched_tb -o mem_sched_sim \
    && ./obj_dir/mem_sched_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }
cat sim.log
grep -q "Testbench failed" sim.log && { echo "Simulation FAILED"; exit 1; }
grep -q "Testbench passed" sim.log || { echo "Simulation FAILED"; exit 1; }
echo "Simulation PASSED"
exit 0
